// File: hdl/dma_reg_pkg.sv
/*
 * DMA register map
 * Bus widths, request table geometry and descriptor slot layout
 */
package dma_reg_pkg;

  // APB side
  localparam int ADDR_WIDTH = 13;
  localparam int DATA_WIDTH = 32;

  // Request table geometry
  localparam int TABLE_ENTRIES   = 4;
  localparam int TABLE_PTR_WIDTH = 2;

  // Byte offsets inside a 32-byte descriptor slot
  localparam logic [4:0] REG_SRC    = 5'h00;
  localparam logic [4:0] REG_DST    = 5'h04;
  localparam logic [4:0] REG_LEN    = 5'h08;
  localparam logic [4:0] REG_STATUS = 5'h14;

  // Field select comes from address bits 4 to 2
  localparam int FIELD_SEL_WIDTH = 3;

  // Set means the access targets local memory
  localparam int MEM_WINDOW_BIT = 12;
  // Word address bits decoded inside the memory window
  localparam int WIN_ADDR_WIDTH = 8;

endpackage

// File: hdl/dma_mem_pkg.sv
/*
 * Local memory definitions
 * Word width, depth, transfer length and arbiter requester slots
 */
package dma_mem_pkg;

  // Memory geometry follows the window decoded on the bus
  localparam int MEM_DATA_WIDTH = dma_reg_pkg::DATA_WIDTH;
  localparam int MEM_ADDR_WIDTH = dma_reg_pkg::WIN_ADDR_WIDTH;
  localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;

  // Up to MEM_DEPTH words per transfer
  localparam int LEN_WIDTH = MEM_ADDR_WIDTH + 1;

  // Requester slots at the arbiter
  localparam logic REQ_HOST   = 1'b0;
  localparam logic REQ_ENGINE = 1'b1;

endpackage

// File: hdl/dma_apb_if.sv
/*
 * APB slave of the DMA tile
 * Decodes descriptor registers, the status register and the memory window
 */
`timescale 1ns/1ps

module dma_apb_if
  import dma_reg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  // APB slave
  input  logic [ADDR_WIDTH-1:0]      paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [DATA_WIDTH-1:0]      pwdata_i,
  output logic [DATA_WIDTH-1:0]      prdata_o,
  output logic                       pready_o,
  // Request table access
  output logic [TABLE_PTR_WIDTH-1:0] tbl_pos_o,
  output logic [FIELD_SEL_WIDTH-1:0] tbl_field_o,
  output logic [DATA_WIDTH-1:0]      tbl_wdata_o,
  output logic                       tbl_we_o,
  output logic                       tbl_start_o,
  output logic                       tbl_status_rd_o,
  input  logic                       tbl_done_i,
  input  logic [DATA_WIDTH-1:0]      tbl_rdata_i,
  // Host side of the memory arbiter
  output logic                       hmem_req_o,
  output logic                       hmem_we_o,
  output logic [WIN_ADDR_WIDTH-1:0]  hmem_addr_o,
  output logic [DATA_WIDTH-1:0]      hmem_wdata_o,
  input  logic                       hmem_gnt_i,
  input  logic [DATA_WIDTH-1:0]      mem_rdata_i
);

  logic access;
  logic win;
  logic is_status;
  logic hmem_req_q;
  logic rd_pend_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign access    = psel_i & penable_i;
  assign win       = paddr_i[MEM_WINDOW_BIT];
  assign is_status = (paddr_i[4:0] == REG_STATUS);

  // Slot index sits above the 32-byte slot offset
  assign tbl_pos_o   = paddr_i[TABLE_PTR_WIDTH+4:5];
  assign tbl_field_o = paddr_i[FIELD_SEL_WIDTH+1:2];
  assign tbl_wdata_o = pwdata_i;

  // Table strobes only in the access phase
  assign tbl_we_o        = access & ~win & pwrite_i & ~is_status;
  assign tbl_start_o     = access & ~win & pwrite_i & is_status;
  assign tbl_status_rd_o = access & ~win & ~pwrite_i & is_status;

  //////////////////////////////
  // Memory window
  //////////////////////////////

  // Address and data stay stable for the whole transfer
  assign hmem_we_o    = pwrite_i;
  assign hmem_addr_o  = paddr_i[WIN_ADDR_WIDTH+1:2];
  assign hmem_wdata_o = pwdata_i;
  assign hmem_req_o   = hmem_req_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hmem_req_q <= 1'b0;
      rd_pend_q  <= 1'b0;
    end else begin
      // Raise in setup phase, hold until granted
      if (hmem_gnt_i) begin
        hmem_req_q <= 1'b0;
      end else if (psel_i && !penable_i && win) begin
        hmem_req_q <= 1'b1;
      end
      // Read data lands one cycle after the grant
      if (hmem_gnt_i && !pwrite_i) begin
        rd_pend_q <= 1'b1;
      end else if (rd_pend_q) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // Registers never wait; window waits for grant or data
  assign pready_o = access & (~win | (pwrite_i & hmem_gnt_i) | (~pwrite_i & rd_pend_q));

  always_comb begin
    if (win) begin
      prdata_o = mem_rdata_i;
    end else if (is_status) begin
      prdata_o = {{(DATA_WIDTH-1){1'b0}}, tbl_done_i};
    end else begin
      prdata_o = tbl_rdata_i;
    end
  end

endmodule

// File: hdl/dma_request_table.sv
/*
 * DMA request table
 * Descriptor storage with per-entry valid and done flags
 */
`timescale 1ns/1ps

module dma_request_table
  import dma_reg_pkg::*;
  import dma_mem_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Host port
  input  logic [TABLE_PTR_WIDTH-1:0] pos_i,
  input  logic [FIELD_SEL_WIDTH-1:0] field_i,
  input  logic [DATA_WIDTH-1:0]      wdata_i,
  input  logic                       we_i,
  input  logic                       start_i,
  input  logic                       status_rd_i,
  output logic [DATA_WIDTH-1:0]      rdata_o,
  output logic                       done_o,
  // Engine port
  output logic [TABLE_ENTRIES-1:0]   valid_o,
  input  logic [TABLE_PTR_WIDTH-1:0] eng_pos_i,
  input  logic                       eng_clear_i,
  output logic [MEM_ADDR_WIDTH-1:0]  src_o,
  output logic [MEM_ADDR_WIDTH-1:0]  dst_o,
  output logic [LEN_WIDTH-1:0]       len_o
);

  logic [MEM_ADDR_WIDTH-1:0] src_q [TABLE_ENTRIES];
  logic [MEM_ADDR_WIDTH-1:0] dst_q [TABLE_ENTRIES];
  logic [LEN_WIDTH-1:0]      len_q [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0]  valid_q;
  logic [TABLE_ENTRIES-1:0]  done_q;

  // Descriptor fields, written by the host only
  always_ff @(posedge clk) begin
    if (we_i) begin
      case (field_i)
        REG_SRC[4:2]: src_q[pos_i] <= wdata_i[MEM_ADDR_WIDTH-1:0];
        REG_DST[4:2]: dst_q[pos_i] <= wdata_i[MEM_ADDR_WIDTH-1:0];
        REG_LEN[4:2]: len_q[pos_i] <= wdata_i[LEN_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Valid and done per entry
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      // Engine completion touches its own entry only
      if (eng_clear_i) begin
        valid_q[eng_pos_i] <= 1'b0;
        done_q[eng_pos_i]  <= 1'b1;
      end
      // A host start wins over a same-cycle completion
      if (start_i) begin
        valid_q[pos_i] <= 1'b1;
        done_q[pos_i]  <= 1'b0;
      end
    end
  end

  // Host readback
  always_comb begin
    case (field_i)
      REG_SRC[4:2]: rdata_o = DATA_WIDTH'(src_q[pos_i]);
      REG_DST[4:2]: rdata_o = DATA_WIDTH'(dst_q[pos_i]);
      REG_LEN[4:2]: rdata_o = DATA_WIDTH'(len_q[pos_i]);
      default:      rdata_o = '0;
    endcase
  end

  assign done_o = status_rd_i & done_q[pos_i];

  // Descriptor the engine points at
  assign valid_o = valid_q;
  assign src_o   = src_q[eng_pos_i];
  assign dst_o   = dst_q[eng_pos_i];
  assign len_o   = len_q[eng_pos_i];

endmodule

// File: hdl/dma_copy_engine.sv
/*
 * DMA copy engine
 * Takes valid entries lowest first and copies words one at a time
 */
`timescale 1ns/1ps

module dma_copy_engine
  import dma_reg_pkg::*;
  import dma_mem_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Request table
  input  logic [TABLE_ENTRIES-1:0]   valid_i,
  input  logic [MEM_ADDR_WIDTH-1:0]  src_i,
  input  logic [MEM_ADDR_WIDTH-1:0]  dst_i,
  input  logic [LEN_WIDTH-1:0]       len_i,
  output logic [TABLE_PTR_WIDTH-1:0] pos_o,
  output logic                       clear_o,
  // Arbiter port
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0]  mem_addr_o,
  output logic [MEM_DATA_WIDTH-1:0]  mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic [MEM_DATA_WIDTH-1:0]  mem_rdata_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_CAPTURE,
    S_WRITE,
    S_FINISH
  } state_t;

  state_t                     state_q;
  logic [TABLE_PTR_WIDTH-1:0] pos_q;
  logic [TABLE_PTR_WIDTH-1:0] next_pos;
  logic [LEN_WIDTH-1:0]       cnt_q;
  logic [MEM_DATA_WIDTH-1:0]  data_q;
  logic                       last;

  // Lowest set valid bit
  always_comb begin
    next_pos = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid_i[i]) begin
        next_pos = TABLE_PTR_WIDTH'(i);
      end
    end
  end

  // All words moved, also true at once for length 0
  assign last = (cnt_q == len_i);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      pos_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (|valid_i) begin
            pos_q   <= next_pos;
            cnt_q   <= '0;
            state_q <= S_READ;
          end
        end
        S_READ: begin
          if (last) begin
            state_q <= S_FINISH;
          end else if (mem_gnt_i) begin
            state_q <= S_CAPTURE;
          end
        end
        // Memory data valid one cycle after the grant
        S_CAPTURE: state_q <= S_WRITE;
        S_WRITE: begin
          if (mem_gnt_i) begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= S_READ;
          end
        end
        S_FINISH: state_q <= S_IDLE;
        default:  state_q <= S_IDLE;
      endcase
    end
  end

  // Captured word, no reset needed
  always_ff @(posedge clk) begin
    if (state_q == S_CAPTURE) begin
      data_q <= mem_rdata_i;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign pos_o   = pos_q;
  assign clear_o = (state_q == S_FINISH);

  assign mem_req_o   = ((state_q == S_READ) & ~last) | (state_q == S_WRITE);
  assign mem_we_o    = (state_q == S_WRITE);
  assign mem_addr_o  = mem_we_o ? dst_i + cnt_q[MEM_ADDR_WIDTH-1:0]
                                : src_i + cnt_q[MEM_ADDR_WIDTH-1:0];
  assign mem_wdata_o = data_q;

endmodule

// File: hdl/dma_mem_arbiter.sv
/*
 * Memory port arbiter
 * Round-robin between host window and copy engine
 */
`timescale 1ns/1ps

module dma_mem_arbiter
  import dma_mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n_i,
  // Host window
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  logic [MEM_ADDR_WIDTH-1:0] host_addr_i,
  input  logic [MEM_DATA_WIDTH-1:0] host_wdata_i,
  // Copy engine
  input  logic                      eng_req_i,
  input  logic                      eng_we_i,
  input  logic [MEM_ADDR_WIDTH-1:0] eng_addr_i,
  input  logic [MEM_DATA_WIDTH-1:0] eng_wdata_i,
  output logic                      host_gnt_o,
  output logic                      eng_gnt_o,
  // Memory port
  output logic                      mem_en_o,
  output logic                      mem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [MEM_DATA_WIDTH-1:0] mem_wdata_o
);

  logic       last_q;
  logic [1:0] req;
  logic [1:0] gnt;

  assign req[REQ_HOST]   = host_req_i;
  assign req[REQ_ENGINE] = eng_req_i;

  // On a tie the side not served last time wins
  always_comb begin
    gnt = '0;
    if (req[REQ_HOST] && req[REQ_ENGINE]) begin
      gnt[~last_q] = 1'b1;
    end else begin
      gnt = req;
    end
  end

  assign host_gnt_o = gnt[REQ_HOST];
  assign eng_gnt_o  = gnt[REQ_ENGINE];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_q <= REQ_ENGINE;
    end else if (|gnt) begin
      last_q <= gnt[REQ_ENGINE] ? REQ_ENGINE : REQ_HOST;
    end
  end

  // Winner drives the port
  assign mem_en_o    = |gnt;
  assign mem_we_o    = eng_gnt_o ? eng_we_i    : host_we_i;
  assign mem_addr_o  = eng_gnt_o ? eng_addr_i  : host_addr_i;
  assign mem_wdata_o = eng_gnt_o ? eng_wdata_i : host_wdata_i;

endmodule

// File: hdl/dma_local_mem.sv
/*
 * Local word memory
 * Single port, synchronous write, one-cycle read latency
 */
`timescale 1ns/1ps

module dma_local_mem
  import dma_mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      en_i,
  input  logic                      we_i,
  input  logic [MEM_ADDR_WIDTH-1:0] addr_i,
  input  logic [MEM_DATA_WIDTH-1:0] wdata_i,
  output logic [MEM_DATA_WIDTH-1:0] rdata_o
);

  logic [MEM_DATA_WIDTH-1:0] mem_q [MEM_DEPTH];

  // Read returns the old word on a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: hdl/dma_top.sv
/*
 * DMA tile top level
 * APB slave, request table, copy engine, arbiter and local memory
 */
`timescale 1ns/1ps

module dma_top
  import dma_reg_pkg::*;
  import dma_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [ADDR_WIDTH-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o
);

  //////////////////////////////
  // Interconnect
  //////////////////////////////

  // Host to table
  logic [TABLE_PTR_WIDTH-1:0] tbl_pos;
  logic [FIELD_SEL_WIDTH-1:0] tbl_field;
  logic [DATA_WIDTH-1:0]      tbl_wdata;
  logic                       tbl_we;
  logic                       tbl_start;
  logic                       tbl_status_rd;
  logic                       tbl_done;
  logic [DATA_WIDTH-1:0]      tbl_rdata;

  // Table to engine
  logic [TABLE_ENTRIES-1:0]   valid;
  logic [TABLE_PTR_WIDTH-1:0] eng_pos;
  logic                       eng_clear;
  logic [MEM_ADDR_WIDTH-1:0]  src;
  logic [MEM_ADDR_WIDTH-1:0]  dst;
  logic [LEN_WIDTH-1:0]       len;

  // Requesters at the arbiter
  logic                       hmem_req;
  logic                       hmem_we;
  logic [MEM_ADDR_WIDTH-1:0]  hmem_addr;
  logic [MEM_DATA_WIDTH-1:0]  hmem_wdata;
  logic                       hmem_gnt;
  logic                       emem_req;
  logic                       emem_we;
  logic [MEM_ADDR_WIDTH-1:0]  emem_addr;
  logic [MEM_DATA_WIDTH-1:0]  emem_wdata;
  logic                       emem_gnt;

  // Memory port, read data shared by both sides
  logic                       mem_en;
  logic                       mem_we;
  logic [MEM_ADDR_WIDTH-1:0]  mem_addr;
  logic [MEM_DATA_WIDTH-1:0]  mem_wdata;
  logic [MEM_DATA_WIDTH-1:0]  mem_rdata;

  dma_apb_if u_apb_if (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .paddr_i         (paddr_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .tbl_pos_o       (tbl_pos),
    .tbl_field_o     (tbl_field),
    .tbl_wdata_o     (tbl_wdata),
    .tbl_we_o        (tbl_we),
    .tbl_start_o     (tbl_start),
    .tbl_status_rd_o (tbl_status_rd),
    .tbl_done_i      (tbl_done),
    .tbl_rdata_i     (tbl_rdata),
    .hmem_req_o      (hmem_req),
    .hmem_we_o       (hmem_we),
    .hmem_addr_o     (hmem_addr),
    .hmem_wdata_o    (hmem_wdata),
    .hmem_gnt_i      (hmem_gnt),
    .mem_rdata_i     (mem_rdata)
  );

  dma_request_table u_request_table (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pos_i       (tbl_pos),
    .field_i     (tbl_field),
    .wdata_i     (tbl_wdata),
    .we_i        (tbl_we),
    .start_i     (tbl_start),
    .status_rd_i (tbl_status_rd),
    .rdata_o     (tbl_rdata),
    .done_o      (tbl_done),
    .valid_o     (valid),
    .eng_pos_i   (eng_pos),
    .eng_clear_i (eng_clear),
    .src_o       (src),
    .dst_o       (dst),
    .len_o       (len)
  );

  dma_copy_engine u_copy_engine (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid),
    .src_i       (src),
    .dst_i       (dst),
    .len_i       (len),
    .pos_o       (eng_pos),
    .clear_o     (eng_clear),
    .mem_req_o   (emem_req),
    .mem_we_o    (emem_we),
    .mem_addr_o  (emem_addr),
    .mem_wdata_o (emem_wdata),
    .mem_gnt_i   (emem_gnt),
    .mem_rdata_i (mem_rdata)
  );

  dma_mem_arbiter u_mem_arbiter (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .host_req_i   (hmem_req),
    .host_we_i    (hmem_we),
    .host_addr_i  (hmem_addr),
    .host_wdata_i (hmem_wdata),
    .eng_req_i    (emem_req),
    .eng_we_i     (emem_we),
    .eng_addr_i   (emem_addr),
    .eng_wdata_i  (emem_wdata),
    .host_gnt_o   (hmem_gnt),
    .eng_gnt_o    (emem_gnt),
    .mem_en_o     (mem_en),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata)
  );

  dma_local_mem u_local_mem (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// File: sim/dma_tb_clkgen.sv
/*
 * Testbench clock and reset
 * 40 ns clock, reset held low for the first 10 rising edges
 */
`timescale 1ns/1ps

module dma_tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int RESET_CYCLES = 10;

  // Half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Released on a rising edge, like any other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: sim/dma_tb.sv
/*
 * DMA tile testbench
 * Runs the operations of the stimulus file over APB and checks every response
 */
`timescale 1ns/1ps

module dma_tb
  import dma_reg_pkg::*;
();

  localparam string STIM_FILE      = "sim/dma_stimulus.txt";
  localparam int    PREADY_TIMEOUT = 200;
  localparam int    POLL_LIMIT     = 400;
  localparam int    RESET_TIMEOUT  = 50;

  logic                  clk;
  logic                  rst_n;
  logic [ADDR_WIDTH-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pready;

  // Check mismatches and run faults (timeouts, bad file lines)
  int     errors;
  int     faults;
  logic   aborted;
  integer seed;

  dma_tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dma_top DUT (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Memory fill pattern, built from every bit of the word address
  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [7:0] a);
    return {a ^ 8'hC3, ~a, a, a + 8'h35};
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error %0s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_access(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                            input logic [DATA_WIDTH-1:0] wdata,
                            output logic [DATA_WIDTH-1:0] rdata);
    int cycles;
    rdata = '0;
    if (aborted) return;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    // pready sampled mid-cycle, away from the driving edge
    cycles = 0;
    @(negedge clk);
    while (!pready && cycles < PREADY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!pready) begin
      $display("Timeout: no pready for the access at address %h", addr);
      faults++;
      aborted = 1'b1;
    end else begin
      rdata = prdata;
    end
    // Transfer ends on this edge
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data);
    logic [DATA_WIDTH-1:0] unused;
    apb_access(addr, 1'b1, data, unused);
  endtask

  task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr,
                          output logic [DATA_WIDTH-1:0] data);
    apb_access(addr, 1'b0, '0, data);
  endtask

  // Status reads until the expected value shows up
  task automatic poll_done(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] expected, input string name);
    logic [DATA_WIDTH-1:0] rd;
    int                    polls;
    rd    = '0;
    polls = 0;
    while (!aborted && (polls == 0 || rd !== expected) && polls < POLL_LIMIT) begin
      apb_read(addr, rd);
      polls++;
    end
    if (!aborted && rd !== expected) begin
      $display("Timeout: %0s status at address %h did not reach %h after %0d reads",
               name, addr, expected, polls);
      faults++;
      aborted = 1'b1;
    end
  endtask

  task automatic fill_range(input logic [ADDR_WIDTH-1:0] base, input int count);
    logic [7:0] word;
    for (int i = 0; i < count; i++) begin
      word = base[WIN_ADDR_WIDTH+1:2] + 8'(i);
      apb_write(base + ADDR_WIDTH'(4 * i), fill_word(word));
    end
  endtask

  // Window words from base against the pattern of words from src_word
  task automatic check_copy(input logic [ADDR_WIDTH-1:0] base, input int count,
                            input logic [7:0] src_word, input string name);
    logic [7:0]            dst_word;
    logic [DATA_WIDTH-1:0] rd;
    for (int i = 0; i < count; i++) begin
      dst_word = base[WIN_ADDR_WIDTH+1:2] + 8'(i);
      apb_read(base + ADDR_WIDTH'(4 * i), rd);
      if (!aborted) begin
        check_value($sformatf("%0s word %h", name, dst_word), fill_word(src_word + 8'(i)), rd);
      end
    end
  endtask

  // Random window writes that compete with the engine, then readback
  task automatic random_traffic(input logic [ADDR_WIDTH-1:0] base, input int count,
                                input string name);
    logic [DATA_WIDTH-1:0] written [$];
    logic [DATA_WIDTH-1:0] value;
    logic [DATA_WIDTH-1:0] rd;
    for (int i = 0; i < count; i++) begin
      value = $random(seed);
      written.push_back(value);
      apb_write(base + ADDR_WIDTH'(4 * i), value);
    end
    for (int i = 0; i < count; i++) begin
      apb_read(base + ADDR_WIDTH'(4 * i), rd);
      if (!aborted) begin
        check_value($sformatf("%0s word %0d", name, i), written[i], rd);
      end
    end
  endtask

  task automatic run_op(input logic [7:0] op, input logic [ADDR_WIDTH-1:0] addr,
                        input logic [DATA_WIDTH-1:0] data,
                        input logic [DATA_WIDTH-1:0] expected, input string name);
    logic [DATA_WIDTH-1:0] rd;
    case (op)
      "W": apb_write(addr, data);
      "R": begin
        apb_read(addr, rd);
        if (!aborted) begin
          check_value(name, expected, rd);
        end
      end
      "P": poll_done(addr, expected, name);
      "F": fill_range(addr, int'(data));
      "C": check_copy(addr, int'(data), expected[7:0], name);
      "X": random_traffic(addr, int'(data), name);
      default: begin
        $display("Unknown op code in stimulus line %0s", name);
        faults++;
      end
    endcase
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    integer                fd;
    integer                code;
    int                    cycles;
    logic                  more;
    logic [8*160-1:0]      line;
    logic [7:0]            op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_WIDTH-1:0] expected;
    logic [8*32-1:0]       name;

    // Bus idle from time zero
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    errors  = 0;
    faults  = 0;
    aborted = 1'b0;
    seed    = 97428;

    // Reset release
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      faults++;
      aborted = 1'b1;
    end

    fd = 0;
    if (!aborted) begin
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
        $display("Could not open the stimulus file %0s", STIM_FILE);
        faults++;
        aborted = 1'b1;
      end
    end

    // One operation per line, comment lines start with #
    more = (fd != 0);
    while (more && !aborted) begin
      line = '0;
      code = $fgets(line, fd);
      if (code == 0) begin
        more = 1'b0;
      end else begin
        op   = '0;
        name = '0;
        code = $sscanf(line, "%s %h %h %h %s", op, addr, data, expected, name);
        if (code == 5) begin
          run_op(op, addr, data, expected, $sformatf("%0s", name));
        end else if (code > 0 && op != "#") begin
          $display("Malformed stimulus line: %0s", line);
          faults++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Check errors: %0d, run errors: %0d", errors, faults);
    if (errors == 0 && faults == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim/dma_stimulus.txt
# op addr data expected name, numbers in hex, addr is the APB byte address
# W write, R read and compare, P poll until equal, F fill data words with the address pattern
# C compare data words from addr with the pattern of words from expected, X data random writes
R 0014 0 0 reset_status_0
R 0034 0 0 reset_status_1
R 0054 0 0 reset_status_2
R 0074 0 0 reset_status_3
W 0060 ab 0 desc_src_wr
W 0064 cd 0 desc_dst_wr
W 0068 100 0 desc_len_wr
R 0060 0 ab desc_src_rd
R 0064 0 cd desc_dst_rd
R 0068 0 100 desc_len_rd
W 1200 12345678 0 win_wr_0
W 1204 cafef00d 0 win_wr_1
R 1200 0 12345678 win_rd_0
R 1204 0 cafef00d win_rd_1
F 1040 8 0 single_src_fill
F 1080 8 0 single_dst_fill
W 0000 10 0 single_src
W 0004 20 0 single_dst
W 0008 5 0 single_len
W 0014 1 0 single_start
P 0014 0 1 single_done
C 1080 5 10 single_copy
C 1094 3 25 single_beyond
F 1100 10 0 dual_src_fill
W 0020 40 0 dual_a_src
W 0024 60 0 dual_a_dst
W 0028 8 0 dual_a_len
W 0040 48 0 dual_b_src
W 0044 70 0 dual_b_dst
W 0048 8 0 dual_b_len
W 0034 1 0 dual_a_start
W 0054 1 0 dual_b_start
X 1300 10 0 dual_traffic
P 0034 0 1 dual_a_done
P 0054 0 1 dual_b_done
C 1180 8 40 dual_a_copy
C 11c0 8 48 dual_b_copy
F 1240 4 0 zero_dst_fill
W 0000 10 0 zero_src
W 0004 90 0 zero_dst
W 0008 0 0 zero_len
W 0014 1 0 zero_start
P 0014 0 1 zero_done
C 1240 4 90 zero_unchanged

// File: sources.f
hdl/dma_reg_pkg.sv
hdl/dma_mem_pkg.sv
hdl/dma_apb_if.sv
hdl/dma_request_table.sv
hdl/dma_copy_engine.sv
hdl/dma_mem_arbiter.sv
hdl/dma_local_mem.sv
hdl/dma_top.sv
sim/dma_tb_clkgen.sv
sim/dma_tb.sv

// File: Makefile
# Verilator simulation of the DMA tile
VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
